// File: logic/io_map_pkg.sv
`default_nettype none

package io_map_pkg;

  // byte offset inside the 128 byte io window
  typedef logic [6:0] io_addr_t;

  //////////////////////////////////////////////////
  // write region, lower half of the window
  localparam io_addr_t OFF_OUT_DESC_LO  = 7'h00;
  localparam io_addr_t OFF_OUT_DESC_HI  = 7'h04;
  localparam io_addr_t OFF_DRAM_ADDR_LO = 7'h08;
  localparam io_addr_t OFF_DRAM_ADDR_HI = 7'h0C;
  localparam io_addr_t OFF_SLOT_INFO    = 7'h10;
  localparam io_addr_t OFF_TIMER_STEP   = 7'h14;
  localparam io_addr_t OFF_DRAM_FLAGS   = 7'h18;
  localparam io_addr_t OFF_CMD          = 7'h20;
  localparam io_addr_t OFF_IRQ_MASK     = 7'h24;

  //////////////////////////////////////////////////
  // read region, upper half
  localparam io_addr_t OFF_RD_IN_DESC_LO    = 7'h40;
  localparam io_addr_t OFF_RD_IN_DESC_HI    = 7'h44;
  localparam io_addr_t OFF_RD_DRAM_FLAGS    = 7'h48;
  localparam io_addr_t OFF_RD_STATUS        = 7'h4C;
  localparam io_addr_t OFF_RD_CORE_ID       = 7'h50;
  localparam io_addr_t OFF_RD_TIMER_LO      = 7'h54;
  localparam io_addr_t OFF_RD_TIMER_HI      = 7'h58;
  localparam io_addr_t OFF_RD_IRQ_FLAGS     = 7'h5C;
  localparam io_addr_t OFF_RD_ACTIVE_SLOTS  = 7'h60;

  // bits of the command word, several may be set at once
  localparam int CMD_SEND_DESC    = 0;
  localparam int CMD_TAKE_DESC    = 1;
  localparam int CMD_SLOT_WR      = 2;
  localparam int CMD_FLAG_CLR     = 3;
  localparam int CMD_FLAG_TAG_LSB = 16;
  localparam int CMD_ACK_EXT      = 12;
  localparam int CMD_ACK_TIMER    = 13;

  // interrupt source bit positions
  typedef enum logic [1:0] {
    EXT     = 2'd0,
    TIMER   = 2'd1,
    DRAM    = 2'd2,
    IN_DESC = 2'd3
  } irq_src_e;

  // only the external line enabled out of reset
  localparam logic [3:0]  IRQ_MASK_RESET   = 4'h1;
  localparam logic [31:0] TIMER_STEP_RESET = 32'd1;

endpackage

`default_nettype wire

// File: logic/core_io_types_pkg.sv
`default_nettype none

package core_io_types_pkg;

  import io_map_pkg::*;

  typedef logic [31:0] word_t;
  typedef logic [63:0] desc_t;
  typedef logic [4:0]  dram_tag_t;
  typedef logic [3:0]  irq_mask_t;
  typedef logic [3:0]  desc_type_t;

  // descriptor fields
  localparam int DESC_TYPE_LSB = 60;
  localparam int DESC_SLOT_LSB = 16;

  typedef struct packed {
    logic     psel;
    logic     penable;
    logic     pwrite;
    io_addr_t paddr;
    word_t    pwdata;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  // ptr wide enough for up to 255 slots
  typedef struct packed {
    logic        for_hdr;
    logic [7:0]  ptr;
    logic [24:0] addr;
  } slot_wr_t;

endpackage

`default_nettype wire

// File: logic/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs
  import io_map_pkg::*;
  import core_io_types_pkg::*;
#(
  parameter int CORE_ID_WIDTH = 4,
  parameter int SLOT_COUNT    = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  input  apb_req_t                 apb_req,
  output apb_rsp_t                 apb_rsp,
  input  logic [CORE_ID_WIDTH-1:0] core_id,
  input  desc_t                    in_desc,
  input  logic                     in_desc_valid,
  input  logic                     slot_wr_ready,
  input  logic                     out_desc_ready,
  input  logic                     core_msg_ready,
  input  logic                     interrupt_in,
  input  logic                     out_desc_valid,
  input  logic [SLOT_COUNT:1]      active_slots,
  input  word_t                    flags,
  input  logic [63:0]              timer_now,
  input  logic [3:0]               irq_src,
  output irq_mask_t                irq_mask,
  output desc_t                    out_desc_data,
  output desc_t                    dram_addr,
  output slot_wr_t                 slot_wr,
  output logic                     slot_wr_valid,
  output logic                     send,
  output logic                     take,
  output logic                     flags_wen,
  output word_t                    flags_wdata,
  output logic                     flag_clr,
  output dram_tag_t                flag_clr_tag,
  output word_t                    timer_step,
  output logic                     step_wen,
  output logic                     ack_ext,
  output logic                     ack_timer
);

  logic  access;
  logic  wr_en;
  logic  cmd_wr;
  logic  rd_first;
  logic  rd_wait_q;
  logic  wr_hit;
  logic  rd_hit;
  word_t rd_data;
  word_t prdata_q;
  logic  rd_err_q;
  word_t slot_info_q;

  //////////////////////////////////////////////////
  // apb handshake
  assign access   = apb_req.psel && apb_req.penable;
  assign wr_en    = access && apb_req.pwrite;
  // first access cycle of a read, data sampled here
  assign rd_first = access && !apb_req.pwrite && !rd_wait_q;
  assign cmd_wr   = wr_en && (apb_req.paddr == OFF_CMD);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_wait_q <= 1'b0;
    end else begin
      rd_wait_q <= rd_first;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_first) begin
      prdata_q <= rd_data;
      rd_err_q <= !rd_hit;
    end
  end

  // writes finish at once, reads one wait state later
  assign apb_rsp = '{
    prdata:  prdata_q,
    pready:  apb_req.pwrite || rd_wait_q,
    pslverr: apb_req.pwrite ? !wr_hit : rd_err_q
  };

  //////////////////////////////////////////////////
  // write decode
  always_comb begin
    case (apb_req.paddr)
      OFF_OUT_DESC_LO, OFF_OUT_DESC_HI, OFF_DRAM_ADDR_LO, OFF_DRAM_ADDR_HI,
      OFF_SLOT_INFO, OFF_TIMER_STEP, OFF_DRAM_FLAGS, OFF_CMD,
      OFF_IRQ_MASK: wr_hit = 1'b1;
      default:      wr_hit = 1'b0;
    endcase
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (apb_req.paddr)
        OFF_OUT_DESC_LO:  out_desc_data[31:0]  <= apb_req.pwdata;
        OFF_OUT_DESC_HI:  out_desc_data[63:32] <= apb_req.pwdata;
        OFF_DRAM_ADDR_LO: dram_addr[31:0]      <= apb_req.pwdata;
        OFF_DRAM_ADDR_HI: dram_addr[63:32]     <= apb_req.pwdata;
        OFF_SLOT_INFO:    slot_info_q          <= apb_req.pwdata;
        default: ;
      endcase
    end
  end

  // step of 1 by default, else an irq every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      timer_step <= TIMER_STEP_RESET;
      irq_mask   <= IRQ_MASK_RESET;
    end else if (wr_en) begin
      if (apb_req.paddr == OFF_TIMER_STEP) begin
        timer_step <= apb_req.pwdata;
      end
      if (apb_req.paddr == OFF_IRQ_MASK) begin
        irq_mask <= apb_req.pwdata[3:0];
      end
    end
  end

  assign step_wen    = wr_en && (apb_req.paddr == OFF_TIMER_STEP);
  assign flags_wen   = wr_en && (apb_req.paddr == OFF_DRAM_FLAGS);
  assign flags_wdata = apb_req.pwdata;

  // command strobes, one cycle each
  assign send          = cmd_wr && apb_req.pwdata[CMD_SEND_DESC];
  assign take          = cmd_wr && apb_req.pwdata[CMD_TAKE_DESC];
  assign slot_wr_valid = cmd_wr && apb_req.pwdata[CMD_SLOT_WR];
  assign flag_clr      = cmd_wr && apb_req.pwdata[CMD_FLAG_CLR];
  assign flag_clr_tag  = apb_req.pwdata[CMD_FLAG_TAG_LSB +: $bits(dram_tag_t)];
  assign ack_ext       = cmd_wr && apb_req.pwdata[CMD_ACK_EXT];
  assign ack_timer     = cmd_wr && apb_req.pwdata[CMD_ACK_TIMER];

  // header goes to data mem, packet to packet mem, so top addr bit flips
  assign slot_wr = '{
    for_hdr: slot_info_q[23],
    ptr:     slot_info_q[31:24],
    addr:    {~slot_info_q[23], slot_info_q[23:0]}
  };

  //////////////////////////////////////////////////
  // read mux
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (apb_req.paddr)
      OFF_RD_IN_DESC_LO:   rd_data = in_desc[31:0];
      OFF_RD_IN_DESC_HI:   rd_data = in_desc[63:32];
      OFF_RD_DRAM_FLAGS:   rd_data = flags;
      // one flag per byte, plus line levels in bit 1
      OFF_RD_STATUS:       rd_data = {7'd0, core_msg_ready, 7'd0, slot_wr_ready,
                                      6'd0, out_desc_valid, out_desc_ready,
                                      6'd0, interrupt_in, in_desc_valid};
      OFF_RD_CORE_ID:      rd_data = {{(32-CORE_ID_WIDTH){1'b0}}, core_id};
      OFF_RD_TIMER_LO:     rd_data = timer_now[31:0];
      OFF_RD_TIMER_HI:     rd_data = timer_now[63:32];
      OFF_RD_IRQ_FLAGS:    rd_data = {20'd0, irq_mask, 4'd0, irq_src};
      // slot n sits at bit n, bit 0 unused
      OFF_RD_ACTIVE_SLOTS: rd_data = {{(31-SLOT_COUNT){1'b0}}, active_slots, 1'b0};
      default:             rd_hit  = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/desc_port.sv
`timescale 1ns/1ps
`default_nettype none

module desc_port
  import core_io_types_pkg::*;
#(
  parameter int SLOT_COUNT = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                send,
  input  logic                take,
  input  desc_t               out_desc_data,
  output desc_t               out_desc,
  output logic                out_desc_valid,
  input  logic                out_desc_ready,
  input  desc_t               in_desc,
  input  logic                in_desc_valid,
  output logic                in_desc_taken,
  output logic [SLOT_COUNT:1] active_slots
);

  localparam int SLOT_WIDTH = $clog2(SLOT_COUNT + 1);

  logic                  handshake;
  logic                  slot_done;
  desc_type_t            out_type;
  logic [SLOT_WIDTH-1:0] in_slot;
  logic [SLOT_WIDTH-1:0] out_slot;
  logic [SLOT_COUNT:1]   set_vec;
  logic [SLOT_COUNT:1]   clr_vec;

  assign in_desc_taken = take && in_desc_valid;
  assign handshake     = out_desc_valid && out_desc_ready;

  // types 0 to 2 finish with their slot
  assign out_type  = out_desc[DESC_TYPE_LSB +: $bits(desc_type_t)];
  assign slot_done = handshake && (out_type < desc_type_t'(3));
  assign in_slot   = in_desc[DESC_SLOT_LSB +: SLOT_WIDTH];
  assign out_slot  = out_desc[DESC_SLOT_LSB +: SLOT_WIDTH];

  //////////////////////////////////////////////////
  // outgoing descriptor hold
  // captured on send, so later reg writes leave it stable
  always_ff @(posedge clk) begin
    if (send) begin
      out_desc <= out_desc_data;
    end
  end

  // send while pending recaptures and stays valid
  always_ff @(posedge clk) begin
    if (rst) begin
      out_desc_valid <= 1'b0;
    end else if (send) begin
      out_desc_valid <= 1'b1;
    end else if (handshake) begin
      out_desc_valid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // active slot bitmap
  always_comb begin
    for (int i = 1; i <= SLOT_COUNT; i++) begin
      set_vec[i] = in_desc_taken && (in_slot == SLOT_WIDTH'(i));
      clr_vec[i] = slot_done && (out_slot == SLOT_WIDTH'(i));
    end
  end

  // take wins on the same slot
  always_ff @(posedge clk) begin
    if (rst) begin
      active_slots <= '0;
    end else begin
      active_slots <= (active_slots & ~clr_vec) | set_vec;
    end
  end

endmodule

`default_nettype wire

// File: logic/dram_flags.sv
`timescale 1ns/1ps
`default_nettype none

module dram_flags
  import core_io_types_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dram_tag_t recv_dram_tag,
  input  logic      recv_dram_tag_valid,
  input  logic      flags_wen,
  input  word_t     flags_wdata,
  input  logic      flag_clr,
  input  dram_tag_t flag_clr_tag,
  output word_t     flags,
  output logic      dram_recv_any
);

  dram_tag_t tag_q;
  logic      tag_valid_q;
  word_t     flags_nxt;

  // input stage for timing
  always_ff @(posedge clk) begin
    tag_q <= recv_dram_tag;
    if (rst) begin
      tag_valid_q <= 1'b0;
    end else begin
      tag_valid_q <= recv_dram_tag_valid;
    end
  end

  // lowest priority first, incoming tag last
  always_comb begin
    flags_nxt = flags;
    if (flags_wen) begin
      flags_nxt = flags_wdata;
    end
    if (flag_clr) begin
      flags_nxt[flag_clr_tag] = 1'b0;
    end
    if (tag_valid_q) begin
      flags_nxt[tag_q] = 1'b1;
    end
    // tag 0 means no flag
    flags_nxt[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      flags <= flags_nxt;
    end
  end

  assign dram_recv_any = |flags;

endmodule

`default_nettype wire

// File: logic/irq_timer.sv
`timescale 1ns/1ps
`default_nettype none

module irq_timer
  import io_map_pkg::*;
  import core_io_types_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  word_t       timer_step,
  input  logic        step_wen,
  input  logic        ack_ext,
  input  logic        ack_timer,
  input  irq_mask_t   irq_mask,
  input  logic        interrupt_in,
  input  logic        dram_recv_any,
  input  logic        in_desc_valid,
  output logic [63:0] timer_now,
  output logic [3:0]  irq_src,
  output logic        interrupt_in_ack,
  output logic        irq
);

  word_t interval_q;
  logic  timer_irq_q;

  //////////////////////////////////////////////////
  // free running 64 bit timer
  always_ff @(posedge clk) begin
    if (rst) begin
      timer_now <= '0;
    end else begin
      timer_now <= timer_now + 64'd1;
    end
  end

  // interval counter, 0 up to step then wrap
  // new step restarts the count and drops a pending irq
  always_ff @(posedge clk) begin
    if (rst) begin
      interval_q  <= '0;
      timer_irq_q <= 1'b0;
    end else if (step_wen) begin
      interval_q  <= '0;
      timer_irq_q <= 1'b0;
    end else if (interval_q == timer_step) begin
      interval_q  <= '0;
      timer_irq_q <= 1'b1;
    end else begin
      interval_q <= interval_q + word_t'(1);
      if (ack_timer) begin
        timer_irq_q <= 1'b0;
      end
    end
  end

  // ack to the external source, one cycle late
  always_ff @(posedge clk) begin
    if (rst) begin
      interrupt_in_ack <= 1'b0;
    end else begin
      interrupt_in_ack <= ack_ext;
    end
  end

  //////////////////////////////////////////////////
  // source levels and masked combine
  always_comb begin
    irq_src          = '0;
    irq_src[EXT]     = interrupt_in;
    irq_src[TIMER]   = timer_irq_q;
    irq_src[DRAM]    = dram_recv_any;
    irq_src[IN_DESC] = in_desc_valid;
  end

  assign irq = |(irq_src & irq_mask);

endmodule

`default_nettype wire

// File: logic/core_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_io_top
  import core_io_types_pkg::*;
#(
  parameter int CORE_ID_WIDTH = 4,
  parameter int SLOT_COUNT    = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  input  apb_req_t                 apb_req,
  output apb_rsp_t                 apb_rsp,
  input  logic [CORE_ID_WIDTH-1:0] core_id,
  input  desc_t                    in_desc,
  input  logic                     in_desc_valid,
  output logic                     in_desc_taken,
  input  dram_tag_t                recv_dram_tag,
  input  logic                     recv_dram_tag_valid,
  output desc_t                    out_desc,
  output logic                     out_desc_valid,
  input  logic                     out_desc_ready,
  output desc_t                    dram_addr,
  output slot_wr_t                 slot_wr,
  output logic                     slot_wr_valid,
  input  logic                     slot_wr_ready,
  input  logic                     core_msg_ready,
  input  logic                     interrupt_in,
  output logic                     interrupt_in_ack,
  output logic                     irq
);

  desc_t               out_desc_data;
  logic                send;
  logic                take;
  logic [SLOT_COUNT:1] active_slots;
  logic                flags_wen;
  word_t               flags_wdata;
  logic                flag_clr;
  dram_tag_t           flag_clr_tag;
  word_t               flags;
  logic                dram_recv_any;
  word_t               timer_step;
  logic                step_wen;
  logic                ack_ext;
  logic                ack_timer;
  irq_mask_t           irq_mask;
  logic [63:0]         timer_now;
  logic [3:0]          irq_src;

  // register block, decode and read mux
  io_regs #(
    .CORE_ID_WIDTH(CORE_ID_WIDTH),
    .SLOT_COUNT   (SLOT_COUNT)
  ) io_regs_inst (
    .clk, .rst, .apb_req, .apb_rsp, .core_id, .in_desc, .in_desc_valid,
    .slot_wr_ready, .out_desc_ready, .core_msg_ready, .interrupt_in,
    .out_desc_valid, .active_slots, .flags, .timer_now, .irq_src, .irq_mask,
    .out_desc_data, .dram_addr, .slot_wr, .slot_wr_valid, .send, .take,
    .flags_wen, .flags_wdata, .flag_clr, .flag_clr_tag, .timer_step,
    .step_wen, .ack_ext, .ack_timer
  );

  desc_port #(
    .SLOT_COUNT(SLOT_COUNT)
  ) desc_port_inst (
    .clk, .rst, .send, .take, .out_desc_data, .out_desc, .out_desc_valid,
    .out_desc_ready, .in_desc, .in_desc_valid, .in_desc_taken, .active_slots
  );

  dram_flags dram_flags_inst (
    .clk, .rst, .recv_dram_tag, .recv_dram_tag_valid, .flags_wen,
    .flags_wdata, .flag_clr, .flag_clr_tag, .flags, .dram_recv_any
  );

  irq_timer irq_timer_inst (
    .clk, .rst, .timer_step, .step_wen, .ack_ext, .ack_timer, .irq_mask,
    .interrupt_in, .dram_recv_any, .in_desc_valid, .timer_now, .irq_src,
    .interrupt_in_ack, .irq
  );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // 10 ns period, starts low
  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

endmodule

`default_nettype wire

// File: bench/core_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_io_tb
  import io_map_pkg::*;
  import core_io_types_pkg::*;
();

  localparam logic [31:0] SEED    = 32'hc0e8;
  localparam logic [3:0]  CORE_ID = 4'hA;
  // per test cycle budgets plus slack for reset
  localparam int TIMEOUT_CYCLES = 80 + 80 + 120 + 100 + 80 + 200;

  logic      clk;
  logic      rst;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  logic [3:0] core_id;
  desc_t     in_desc;
  logic      in_desc_valid;
  logic      in_desc_taken;
  dram_tag_t recv_dram_tag;
  logic      recv_dram_tag_valid;
  desc_t     out_desc;
  logic      out_desc_valid;
  logic      out_desc_ready;
  desc_t     dram_addr;
  slot_wr_t  slot_wr;
  logic      slot_wr_valid;
  logic      slot_wr_ready;
  logic      core_msg_ready;
  logic      interrupt_in;
  logic      interrupt_in_ack;
  logic      irq;

  int       cycle_count    = 0;
  int       slot_wr_pulses = 0;
  int       taken_pulses   = 0;
  int       ack_pulses     = 0;
  slot_wr_t slot_seen;

  tb_clock tb_clock_inst (.clk);

  core_io_top #(
    .CORE_ID_WIDTH(4),
    .SLOT_COUNT   (8)
  ) core_io_top_inst (.*);

  //////////////////////////////////////////////////
  // error handling and compare tasks
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      stop_run("word compare failed");
    end
  endtask

  task automatic check_desc(input string name, input desc_t got, input desc_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      stop_run("descriptor compare failed");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      stop_run("bit compare failed");
    end
  endtask

  task automatic check_slot(input string name, input slot_wr_t got, input slot_wr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      stop_run("slot write compare failed");
    end
  endtask

  // run length guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      stop_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  // pulse counters sampled mid cycle
  always @(negedge clk) begin
    if (slot_wr_valid) begin
      slot_wr_pulses++;
      slot_seen = slot_wr;
    end
    if (in_desc_taken) taken_pulses++;
    if (interrupt_in_ack) ack_pulses++;
  end

  //////////////////////////////////////////////////
  // apb master
  // setup, then access until pready, then idle
  task automatic apb_xfer(input logic wr, input io_addr_t addr, input word_t wdata,
                          output word_t rdata, output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      waits++;
      if (waits > 4) stop_run("APB transfer never raised pready");
      @(negedge clk);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input io_addr_t addr, input word_t data);
    word_t rd;
    logic  err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_bit("pslverr", err, 1'b0);
  endtask

  task automatic apb_read(input io_addr_t addr, output word_t data);
    logic err;
    apb_xfer(1'b0, addr, '0, data, err);
    check_bit("pslverr", err, 1'b0);
  endtask

  function automatic word_t cmd_bit(input int pos);
    return word_t'(1) << pos;
  endfunction

  // mask in 11:8, raw sources in 3:0
  function automatic word_t irq_flags_word(input irq_mask_t mask, input logic [3:0] src);
    return {20'd0, mask, 4'd0, src};
  endfunction

  task automatic send_tag(input dram_tag_t tag);
    @(posedge clk);
    recv_dram_tag       <= tag;
    recv_dram_tag_valid <= 1'b1;
    @(posedge clk);
    recv_dram_tag_valid <= 1'b0;
  endtask

  // load both words, send, wait for the handshake
  task automatic send_out_desc(input word_t hi, input word_t lo);
    int n;
    n = 0;
    apb_write(OFF_OUT_DESC_LO, lo);
    apb_write(OFF_OUT_DESC_HI, hi);
    apb_write(OFF_CMD, cmd_bit(CMD_SEND_DESC));
    @(negedge clk);
    while (out_desc_valid) begin
      n++;
      if (n > 4) stop_run("outgoing descriptor was never accepted");
      @(negedge clk);
    end
  endtask

  task automatic wait_irq(input int limit, output int at);
    int n;
    n = 0;
    @(negedge clk);
    while (!irq) begin
      n++;
      if (n >= limit) stop_run("irq did not rise in time");
      @(negedge clk);
    end
    at = cycle_count;
  endtask

  //////////////////////////////////////////////////
  // directed tests
  task automatic test_out_desc();
    word_t lo;
    word_t hi;
    word_t a_lo;
    word_t a_hi;
    lo   = $urandom;
    hi   = $urandom;
    a_lo = $urandom;
    a_hi = $urandom;
    apb_write(OFF_OUT_DESC_LO, lo);
    apb_write(OFF_OUT_DESC_HI, hi);
    apb_write(OFF_CMD, cmd_bit(CMD_SEND_DESC));
    // ready held low so data and valid must hold
    repeat (20) begin
      @(negedge clk);
      check_bit("out_desc_valid", out_desc_valid, 1'b1);
      check_desc("out_desc", out_desc, {hi, lo});
    end
    @(posedge clk);
    out_desc_ready <= 1'b1;
    // handshake cycle, then valid gone
    @(negedge clk);
    check_bit("out_desc_valid", out_desc_valid, 1'b1);
    @(negedge clk);
    check_bit("out_desc_valid", out_desc_valid, 1'b0);
    @(posedge clk);
    out_desc_ready <= 1'b0;
    apb_write(OFF_DRAM_ADDR_LO, a_lo);
    apb_write(OFF_DRAM_ADDR_HI, a_hi);
    @(negedge clk);
    check_desc("dram_addr", dram_addr, {a_hi, a_lo});
  endtask

  task automatic test_in_desc_slots();
    word_t lo;
    word_t hi;
    word_t rd;
    int    taken;
    hi = $urandom;
    lo = $urandom;
    // slot 5 in the bits from 16 up
    lo[31:16] = 16'd5;
    @(posedge clk);
    in_desc       <= {hi, lo};
    in_desc_valid <= 1'b1;
    apb_read(OFF_RD_IN_DESC_LO, rd);
    check_word("in_desc lo", rd, lo);
    apb_read(OFF_RD_IN_DESC_HI, rd);
    check_word("in_desc hi", rd, hi);
    taken = taken_pulses;
    apb_write(OFF_CMD, cmd_bit(CMD_TAKE_DESC));
    if (taken_pulses != taken + 1) stop_run("in_desc_taken did not pulse once on take");
    apb_read(OFF_RD_ACTIVE_SLOTS, rd);
    check_word("active slots", rd, word_t'(1) << 5);
    @(posedge clk);
    in_desc_valid  <= 1'b0;
    out_desc_ready <= 1'b1;
    // type 7 keeps the slot, type 1 frees it
    send_out_desc(32'h7000_0000, 32'h0005_0000);
    apb_read(OFF_RD_ACTIVE_SLOTS, rd);
    check_word("active slots", rd, word_t'(1) << 5);
    send_out_desc(32'h1000_0000, 32'h0005_0000);
    apb_read(OFF_RD_ACTIVE_SLOTS, rd);
    check_word("active slots", rd, '0);
    @(posedge clk);
    out_desc_ready <= 1'b0;
  endtask

  task automatic test_dram_flags();
    word_t     exp;
    word_t     rd;
    dram_tag_t tag;
    exp = '0;
    send_tag(5'd9);
    exp[9] = 1'b1;
    repeat (6) begin
      tag = dram_tag_t'($urandom);
      send_tag(tag);
      if (tag != 5'd0) exp[tag] = 1'b1;
    end
    send_tag(5'd0);
    apb_read(OFF_RD_DRAM_FLAGS, rd);
    check_word("dram flags", rd, exp);
    apb_write(OFF_CMD, cmd_bit(CMD_FLAG_CLR) | (word_t'(9) << CMD_FLAG_TAG_LSB));
    exp[9] = 1'b0;
    apb_read(OFF_RD_DRAM_FLAGS, rd);
    check_word("dram flags", rd, exp);
    send_tag(5'd12);
    exp[12] = 1'b1;
    // registered tag lands in the clear's access cycle
    fork
      apb_write(OFF_CMD, cmd_bit(CMD_FLAG_CLR) | (word_t'(12) << CMD_FLAG_TAG_LSB));
      begin
        @(posedge clk);
        recv_dram_tag       <= 5'd12;
        recv_dram_tag_valid <= 1'b1;
        @(posedge clk);
        recv_dram_tag_valid <= 1'b0;
      end
    join
    apb_read(OFF_RD_DRAM_FLAGS, rd);
    check_word("dram flags", rd, exp);
    // flags pending but masked off
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    apb_write(OFF_IRQ_MASK, word_t'(1) << DRAM);
    @(negedge clk);
    check_bit("irq", irq, 1'b1);
    // timer still pending since reset and never acked
    apb_read(OFF_RD_IRQ_FLAGS, rd);
    check_word("irq flags", rd, irq_flags_word(4'h4, 4'b0110));
    apb_write(OFF_DRAM_FLAGS, 32'hF0F0_0001);
    apb_read(OFF_RD_DRAM_FLAGS, rd);
    check_word("dram flags", rd, 32'hF0F0_0000);
    apb_write(OFF_DRAM_FLAGS, '0);
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    apb_read(OFF_RD_IRQ_FLAGS, rd);
    check_word("irq flags", rd, irq_flags_word(4'h4, 4'b0010));
  endtask

  task automatic test_timer_irq();
    int          t0;
    int          rise1;
    int          rise2;
    word_t       hi;
    word_t       lo;
    logic [63:0] prev;
    logic [63:0] cur;
    apb_write(OFF_IRQ_MASK, word_t'(1) << TIMER);
    apb_write(OFF_TIMER_STEP, 32'd9);
    @(negedge clk);
    t0 = cycle_count;
    check_bit("irq", irq, 1'b0);
    // step 9 gives one irq every 10 cycles
    wait_irq(12, rise1);
    if (rise1 - t0 != 10) stop_run("timer irq did not rise 10 cycles after the step write");
    apb_write(OFF_CMD, cmd_bit(CMD_ACK_TIMER));
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    wait_irq(12, rise2);
    if (rise2 - rise1 != 10) stop_run("timer irq period is not 10 cycles");
    prev = '0;
    repeat (3) begin
      apb_read(OFF_RD_TIMER_HI, hi);
      apb_read(OFF_RD_TIMER_LO, lo);
      cur = {hi, lo};
      if (cur <= prev) stop_run("timer read did not advance");
      prev = cur;
    end
    apb_write(OFF_IRQ_MASK, word_t'(IRQ_MASK_RESET));
  endtask

  // one flag per byte in bit 0 of each
  task automatic check_status(input logic in_v, input logic out_r, input logic slot_r,
                              input logic msg_r);
    word_t rd;
    @(posedge clk);
    in_desc_valid  <= in_v;
    out_desc_ready <= out_r;
    slot_wr_ready  <= slot_r;
    core_msg_ready <= msg_r;
    apb_read(OFF_RD_STATUS, rd);
    check_word("status", rd, {7'd0, msg_r, 7'd0, slot_r, 7'd0, out_r, 7'd0, in_v});
  endtask

  task automatic test_slot_status_id();
    word_t    info;
    word_t    rd;
    slot_wr_t exp;
    int       pulses;
    logic     err;
    info = $urandom;
    apb_write(OFF_SLOT_INFO, info);
    pulses = slot_wr_pulses;
    apb_write(OFF_CMD, cmd_bit(CMD_SLOT_WR));
    if (slot_wr_pulses != pulses + 1) stop_run("slot_wr_valid did not pulse once");
    exp.ptr     = info[31:24];
    exp.for_hdr = info[23];
    exp.addr    = {~info[23], info[23:0]};
    check_slot("slot_wr", slot_seen, exp);
    check_status(1'b1, 1'b0, 1'b1, 1'b0);
    check_status(1'b0, 1'b1, 1'b0, 1'b1);
    apb_read(OFF_RD_CORE_ID, rd);
    check_word("core id", rd, word_t'(CORE_ID));
    pulses = ack_pulses;
    apb_write(OFF_CMD, cmd_bit(CMD_ACK_EXT));
    // quiet in the command cycle, high for the one after
    if (ack_pulses != pulses) stop_run("interrupt_in_ack rose in the command cycle");
    @(negedge clk);
    check_bit("interrupt_in_ack", interrupt_in_ack, 1'b1);
    @(negedge clk);
    check_bit("interrupt_in_ack", interrupt_in_ack, 1'b0);
    // write into the read region, then an unmapped read
    apb_xfer(1'b1, OFF_RD_IN_DESC_LO, 32'h1234_5678, rd, err);
    check_bit("pslverr", err, 1'b1);
    apb_xfer(1'b0, 7'h7C, '0, rd, err);
    check_bit("pslverr", err, 1'b1);
    @(posedge clk);
    out_desc_ready <= 1'b0;
    core_msg_ready <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    void'($urandom(SEED));
    rst                 = 1'b1;
    apb_req             = '0;
    core_id             = CORE_ID;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    recv_dram_tag       = '0;
    recv_dram_tag_valid = 1'b0;
    out_desc_ready      = 1'b0;
    slot_wr_ready       = 1'b0;
    core_msg_ready      = 1'b0;
    interrupt_in        = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    test_out_desc();
    test_in_desc_slots();
    test_dram_flags();
    test_timer_irq();
    test_slot_status_id();
    @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
logic/io_map_pkg.sv
logic/core_io_types_pkg.sv
logic/io_regs.sv
logic/desc_port.sv
logic/dram_flags.sv
logic/irq_timer.sv
logic/core_io_top.sv
bench/tb_clock.sv
bench/core_io_tb.sv

// File: Makefile
SIM := obj_dir/Vcore_io_tb

.PHONY: all run clean

all: run

# rebuilt only when a listed source or the list changes
$(SIM): build.f $(shell grep -v '^+' build.f)
	verilator --binary --timing --timescale 1ns/1ps --top-module core_io_tb -f build.f

# pass only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
